//--- ooo_golden.txt
# D op v1 q1_wait q1 v2 q2_wait q2 rob_tag expected name, all hex; op 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 mul
# W count waits for that many results in total (decimal); F pulses flush
D 0 00001234 0 0 00000F0F 0 0 0 00002143 alu_add
D 1 00000010 0 0 00000020 0 0 1 FFFFFFF0 alu_sub
D 2 F0F0F0F0 0 0 FF00FF00 0 0 2 F000F000 alu_and
D 3 F0F0F0F0 0 0 0F0F0000 0 0 3 FFFFF0F0 alu_or
D 4 AAAA5555 0 0 FFFF0000 0 0 4 55555555 alu_xor
D 5 00000003 0 0 00000024 0 0 5 00000030 alu_sll
D 6 80000000 0 0 0000001F 0 0 6 00000001 alu_srl
W 7
# Two-deep chain, last link uses the same tag twice
D 0 00000005 0 0 00000007 0 0 7 0000000C chain_head
D 1 00000000 1 7 00000002 0 0 8 0000000A chain_mid
D 5 00000000 1 8 00000000 1 8 9 00002800 chain_same_tag
W 10
# Fourth dispatch lands on the edge where tag A is broadcast
D 0 00000100 0 0 00000001 0 0 A 00000101 fwd_src
D 3 00000001 0 0 00000002 0 0 B 00000003 fwd_pad1
D 4 0000000F 0 0 00000003 0 0 C 0000000C fwd_pad2
D 0 00000000 1 A 00000010 0 0 D 00000111 fwd_same_cycle
W 14
D 7 FFFFFFFF 0 0 FFFFFFFF 0 0 E 00000001 mul_ones
D 0 00000003 0 0 00000004 0 0 F 00000007 add_behind_mul
W 16
D 7 80000001 0 0 00000003 0 0 1 80000003 mul_top_bit
D 1 00000000 1 1 00000001 0 0 2 80000002 sub_on_mul
W 18
# Four waiters fill the station, the fifth is held
D 7 00000006 0 0 00000007 0 0 4 0000002A bp_mul
D 0 00000000 1 4 00000001 0 0 5 0000002B bp_add
D 1 00000064 0 0 00000000 1 4 6 0000003A bp_sub
D 3 00000000 1 4 00000100 0 0 7 0000012A bp_or
D 6 00000000 1 4 00000001 0 0 8 00000015 bp_srl
D 4 0000FFFF 0 0 0000002A 0 0 9 0000FFD5 bp_fifth
W 24
# Tag F was already retired, these two wait forever
D 0 00000000 1 F 00000001 0 0 A 00000000 dead_a
D 1 00000005 0 0 00000000 1 F B 00000000 dead_b
F
D 0 00000009 0 0 00000001 0 0 A 0000000A reuse_a
D 2 00000000 1 A 0000000C 0 0 B 00000008 reuse_b
W 26

//--- all.f
ooo_pkg.sv
reservation_station.sv
exec_unit.sv
ooo_exec_top.sv
ooo_exec_chk.sv
tb_ooo_exec.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_ooo_exec -f all.f
./obj_dir/Vtb_ooo_exec 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- tb_ooo_exec.sv
`timescale 1ns/1ns

module tb_ooo_exec import ooo_pkg::*; ();

    localparam int    RST_CYCLES      = 16;
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    NUM_TAGS        = 2 ** ROB_TAG_W;
    localparam string GOLDEN_FILE     = "ooo_golden.txt";

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      flush_i;
    dispatch_t dispatch_i;
    logic      dispatch_ready_o;
    result_t   cdb_o;

    // Scoreboard, indexed by ROB tag
    data_t exp_data    [NUM_TAGS];
    bit    outstanding [NUM_TAGS];
    string tag_name    [NUM_TAGS];
    int    result_cnt   = 0;
    int    limit_cycles = 0;

    // 40 ns period
    always #20 clk_i = ~clk_i;

    ooo_exec_top dut0 (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_o            (cdb_o)
    );

    bind ooo_exec_top ooo_exec_chk u_chk (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .dispatch_ready_i (dispatch_ready_o),
        .cdb_i            (cdb_o)
    );

    // ------------------------------------------------------------
    // Error reporting and checks
    // ------------------------------------------------------------

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    function automatic int count_outstanding();
        int n;
        n = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            n += int'(outstanding[t]);
        end
        return n;
    endfunction

    // ------------------------------------------------------------
    // CDB monitor, sampled mid-cycle
    // ------------------------------------------------------------

    // Tags that are not outstanding must never be broadcast
    always @(negedge clk_i) begin : cdb_monitor
        if (rst_ni && cdb_o.valid) begin
            if (!outstanding[cdb_o.rob_tag]) begin
                fail_run($sformatf("Unexpected result on tag %0d, nothing is outstanding there",
                                   cdb_o.rob_tag));
            end else begin
                check_value(tag_name[cdb_o.rob_tag], exp_data[cdb_o.rob_tag], cdb_o.data);
                outstanding[cdb_o.rob_tag] = 1'b0;
                result_cnt++;
            end
        end
    end

    // Budget comes from the golden file length
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        fail_run($sformatf("Timeout after %0d cycles, the expected results never arrived",
                           limit_cycles));
    end

    // ------------------------------------------------------------
    // Stimulus helpers, all entered at 2 ns after a rising edge
    // ------------------------------------------------------------

    task automatic count_lines(output int n);
        int    fd;
        string line;
        n  = 0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("Cannot open the golden file for reading");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n++;
            end
            $fclose(fd);
        end
    endtask

    task automatic idle_gap();
        int unsigned gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    // Holds the instruction until the station accepts it
    task automatic send_dispatch(input dispatch_t d, input data_t exp, input string name);
        bit accepted;
        if (outstanding[d.rob_tag]) begin
            fail_run($sformatf("Golden file reuses tag %0d while it is in flight", d.rob_tag));
        end
        exp_data[d.rob_tag]    = exp;
        tag_name[d.rob_tag]    = name;
        outstanding[d.rob_tag] = 1'b1;
        dispatch_i = d;
        accepted   = 1'b0;
        while (!accepted) begin
            // Ready only moves on a clock edge
            @(negedge clk_i);
            accepted = dispatch_ready_o;
            @(posedge clk_i);
            #2;
        end
        dispatch_i = '0;
    endtask

    task automatic pulse_flush();
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        // Anything still pending was killed
        for (int t = 0; t < NUM_TAGS; t++) begin
            outstanding[t] = 1'b0;
        end
    endtask

    task automatic run_golden();
        int          fd;
        int          code;
        int          wait_n;
        string       cmd;
        string       line;
        string       name;
        bit          prev_disp;
        logic [31:0] f_op, f_v1, f_q1w, f_q1, f_v2, f_q2w, f_q2, f_tag, f_exp;
        dispatch_t   d;
        prev_disp = 1'b0;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("Cannot open the golden file for reading");
        end else begin
            while ($fscanf(fd, " %s", cmd) == 1) begin
                if (cmd.substr(0, 0) == "#") begin
                    code = $fgets(line, fd);
                end else if (cmd == "D") begin
                    code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %s", f_op, f_v1, f_q1w,
                                   f_q1, f_v2, f_q2w, f_q2, f_tag, f_exp, name);
                    if (code != 10) begin
                        fail_run("Malformed dispatch line in the golden file");
                    end
                    d.valid   = 1'b1;
                    d.op      = alu_op_e'(f_op[2:0]);
                    d.v1      = f_v1;
                    d.q1_wait = f_q1w[0];
                    d.q1      = f_q1[ROB_TAG_W-1:0];
                    d.v2      = f_v2;
                    d.q2_wait = f_q2w[0];
                    d.q2      = f_q2[ROB_TAG_W-1:0];
                    d.rob_tag = f_tag[ROB_TAG_W-1:0];
                    // Consecutive D lines stay back-to-back
                    if (!prev_disp) begin
                        idle_gap();
                    end
                    send_dispatch(d, f_exp, name);
                    prev_disp = 1'b1;
                end else if (cmd == "W") begin
                    code = $fscanf(fd, " %d", wait_n);
                    while (result_cnt < wait_n) begin
                        @(posedge clk_i);
                        #2;
                    end
                    prev_disp = 1'b0;
                end else if (cmd == "F") begin
                    pulse_flush();
                    prev_disp = 1'b0;
                end else begin
                    fail_run($sformatf("Unknown command %s in the golden file", cmd));
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin : stimulus
        int lines;
        rst_ni     = 1'b0;
        flush_i    = 1'b0;
        dispatch_i = '0;
        void'($urandom(32'hb947));
        count_lines(lines);
        limit_cycles = lines * CYCLES_PER_LINE + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        run_golden();
        // Quiet window, flushed tags must stay silent
        repeat (10) @(posedge clk_i);
        if (count_outstanding() != 0) begin
            fail_run($sformatf("%0d results never arrived", count_outstanding()));
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- ooo_exec_chk.sv
`timescale 1ns/1ns

module ooo_exec_chk import ooo_pkg::*; (
    input logic    clk_i,
    input logic    rst_ni,
    input logic    flush_i,
    input logic    dispatch_ready_i,
    input result_t cdb_i
);

    // ------------------------------------------------------------
    // Flush behavior
    // ------------------------------------------------------------

    // Flush kills the in-flight ALU and multiplier results
    a_cdb_idle_after_flush: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !cdb_i.valid
    ) else $error("CDB valid in the cycle after a flush");

    // Every entry is free after a flush
    a_ready_after_flush: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> dispatch_ready_i
    ) else $error("Dispatch ready low in the cycle after a flush");

    // ------------------------------------------------------------
    // CDB sanity
    // ------------------------------------------------------------

    a_cdb_valid_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(cdb_i.valid)
    ) else $error("CDB valid is unknown out of reset");

endmodule

//--- ooo_exec_top.sv
`timescale 1ns/1ns

module ooo_exec_top import ooo_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // Renamed instructions in
    input  dispatch_t dispatch_i,
    output logic      dispatch_ready_o,
    // Broadcast towards the ROB
    output result_t   cdb_o
);

    // Station to execution unit
    issue_t  rs_issue;
    logic    exec_ready;

    // CDB, looped back for wake-up
    result_t cdb;

    // ------------------------------------------------------------
    // Reservation station
    // ------------------------------------------------------------

    reservation_station u_rs (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .result_i         (cdb),
        .issue_o          (rs_issue),
        .issue_ready_i    (exec_ready)
    );

    // ------------------------------------------------------------
    // Execution unit
    // ------------------------------------------------------------

    exec_unit u_exec (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .issue_i       (rs_issue),
        .issue_ready_o (exec_ready),
        .cdb_o         (cdb)
    );

    assign cdb_o = cdb;

endmodule

//--- exec_unit.sv
`timescale 1ns/1ns

module exec_unit import ooo_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    flush_i,
    // From the station
    input  issue_t  issue_i,
    output logic    issue_ready_o,
    // CDB out
    output result_t cdb_o
);

    typedef enum logic {
        MUL_IDLE,
        MUL_RUN
    } mul_state_e;

    // Stage 1 operands
    logic     s1_valid_r;
    alu_op_e  s1_op_r;
    data_t    s1_a_r;
    data_t    s1_b_r;
    rob_tag_t s1_tag_r;

    // Stage 2, the CDB register
    logic     cdb_valid_r;
    rob_tag_t cdb_tag_r;
    data_t    cdb_data_r;

    // Multiplier datapath
    mul_state_e           mul_state_r, mul_state_ns;
    logic [MUL_CNT_W-1:0] mul_cnt_r, mul_cnt_ns;
    data_t                mul_mcand_r;
    data_t                mul_mplier_r;
    data_t                mul_acc_r;
    rob_tag_t             mul_tag_r;
    data_t                mul_pp_c;

    logic  do_issue_c;
    logic  alu_issue_c;
    logic  mul_start_c;
    logic  mul_done_c;
    data_t alu_res_c;

    // ------------------------------------------------------------
    // Issue handshake
    // ------------------------------------------------------------

    // Stall issue for the whole multiply
    assign issue_ready_o = (mul_state_r == MUL_IDLE);

    assign do_issue_c  = issue_i.valid && issue_ready_o;
    assign alu_issue_c = do_issue_c && (issue_i.op != OP_MUL);
    assign mul_start_c = do_issue_c && (issue_i.op == OP_MUL);

    // ------------------------------------------------------------
    // ALU, stage 2 logic
    // ------------------------------------------------------------

    always_comb begin : proc_alu
        case (s1_op_r)
            OP_ADD:  alu_res_c = s1_a_r + s1_b_r;
            OP_SUB:  alu_res_c = s1_a_r - s1_b_r;
            OP_AND:  alu_res_c = s1_a_r & s1_b_r;
            OP_OR:   alu_res_c = s1_a_r | s1_b_r;
            OP_XOR:  alu_res_c = s1_a_r ^ s1_b_r;
            OP_SLL:  alu_res_c = s1_a_r << s1_b_r[SHAMT_W-1:0];
            OP_SRL:  alu_res_c = s1_a_r >> s1_b_r[SHAMT_W-1:0];
            // Never enters stage 1
            default: alu_res_c = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Shift-add multiplier
    // ------------------------------------------------------------

    // Partial product of one multiplier nibble, low 32 bits only
    assign mul_pp_c   = mul_mcand_r * data_t'(mul_mplier_r[MUL_STEP_W-1:0]);
    assign mul_done_c = (mul_state_r == MUL_RUN) &&
                        (mul_cnt_r == MUL_CNT_W'(MUL_STEPS - 1));

    always_comb begin : proc_mul_fsm
        mul_state_ns = mul_state_r;
        mul_cnt_ns   = mul_cnt_r;
        case (mul_state_r)
            MUL_IDLE: begin
                if (mul_start_c) begin
                    mul_state_ns = MUL_RUN;
                    mul_cnt_ns   = '0;
                end
            end
            MUL_RUN: begin
                if (mul_done_c) begin
                    mul_state_ns = MUL_IDLE;
                end else begin
                    mul_cnt_ns = mul_cnt_r + 1'b1;
                end
            end
            default: mul_state_ns = MUL_IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl_regs
        if (!rst_ni) begin
            s1_valid_r  <= 1'b0;
            cdb_valid_r <= 1'b0;
            mul_state_r <= MUL_IDLE;
            mul_cnt_r   <= '0;
        end else if (flush_i) begin
            s1_valid_r  <= 1'b0;
            cdb_valid_r <= 1'b0;
            mul_state_r <= MUL_IDLE;
            mul_cnt_r   <= '0;
        end else begin
            s1_valid_r  <= alu_issue_c;
            // Multiply never overlaps a stage 1 op, issue is stalled
            cdb_valid_r <= mul_done_c || s1_valid_r;
            mul_state_r <= mul_state_ns;
            mul_cnt_r   <= mul_cnt_ns;
        end
    end

    always_ff @(posedge clk_i) begin : proc_data_regs
        if (alu_issue_c) begin
            s1_op_r  <= issue_i.op;
            s1_a_r   <= issue_i.v1;
            s1_b_r   <= issue_i.v2;
            s1_tag_r <= issue_i.rob_tag;
        end
        // Final step folds in the last partial product
        if (mul_done_c) begin
            cdb_tag_r  <= mul_tag_r;
            cdb_data_r <= mul_acc_r + mul_pp_c;
        end else if (s1_valid_r) begin
            cdb_tag_r  <= s1_tag_r;
            cdb_data_r <= alu_res_c;
        end
        if (mul_start_c) begin
            mul_mcand_r  <= issue_i.v1;
            mul_mplier_r <= issue_i.v2;
            mul_acc_r    <= '0;
            mul_tag_r    <= issue_i.rob_tag;
        end else if (mul_state_r == MUL_RUN) begin
            mul_acc_r    <= mul_acc_r + mul_pp_c;
            mul_mcand_r  <= mul_mcand_r << MUL_STEP_W;
            mul_mplier_r <= mul_mplier_r >> MUL_STEP_W;
        end
    end

    assign cdb_o.valid   = cdb_valid_r;
    assign cdb_o.rob_tag = cdb_tag_r;
    assign cdb_o.data    = cdb_data_r;

endmodule

//--- reservation_station.sv
`timescale 1ns/1ns

module reservation_station import ooo_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    // Dispatch side
    input  dispatch_t dispatch_i,
    output logic      dispatch_ready_o,
    // CDB snoop
    input  result_t   result_i,
    // Issue side
    output issue_t    issue_o,
    input  logic      issue_ready_i
);

    // Per-entry payload, only meaningful while busy
    typedef struct packed {
        alu_op_e  op;
        data_t    v1;
        rob_tag_t q1;
        data_t    v2;
        rob_tag_t q2;
        rob_tag_t rob_tag;
    } rs_payload_t;

    // Control state
    logic [RS_SIZE-1:0] busy_r, busy_ns;
    logic [RS_SIZE-1:0] q1_wait_r, q1_wait_ns;
    logic [RS_SIZE-1:0] q2_wait_r, q2_wait_ns;

    // Payload storage
    rs_payload_t [RS_SIZE-1:0] ent_r, ent_ns;

    logic [RS_SIZE-1:0] ready_c;
    rs_idx_t            alloc_idx_c;
    rs_idx_t            issue_idx_c;
    logic               any_free_c;
    logic               any_ready_c;
    logic               do_dispatch_c;
    logic               do_issue_c;
    logic               disp_hit1_c;
    logic               disp_hit2_c;

    // ------------------------------------------------------------
    // Allocation and issue select
    // ------------------------------------------------------------

    // Entry may issue once both operands are present
    assign ready_c = busy_r & ~q1_wait_r & ~q2_wait_r;

    // Lowest free slot, scanned top down so index 0 wins
    always_comb begin : proc_alloc_sel
        alloc_idx_c = '0;
        any_free_c  = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy_r[i]) begin
                alloc_idx_c = rs_idx_t'(i);
                any_free_c  = 1'b1;
            end
        end
    end

    // Lowest ready entry
    always_comb begin : proc_issue_sel
        issue_idx_c = '0;
        any_ready_c = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (ready_c[i]) begin
                issue_idx_c = rs_idx_t'(i);
                any_ready_c = 1'b1;
            end
        end
    end

    assign dispatch_ready_o = any_free_c;

    assign issue_o.valid   = any_ready_c;
    assign issue_o.op      = ent_r[issue_idx_c].op;
    assign issue_o.v1      = ent_r[issue_idx_c].v1;
    assign issue_o.v2      = ent_r[issue_idx_c].v2;
    assign issue_o.rob_tag = ent_r[issue_idx_c].rob_tag;

    assign do_dispatch_c = dispatch_i.valid && any_free_c;
    assign do_issue_c    = any_ready_c && issue_ready_i;

    // Incoming operand already on the CDB this cycle
    assign disp_hit1_c = result_i.valid && dispatch_i.q1_wait &&
                         (dispatch_i.q1 == result_i.rob_tag);
    assign disp_hit2_c = result_i.valid && dispatch_i.q2_wait &&
                         (dispatch_i.q2 == result_i.rob_tag);

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------

    always_comb begin : proc_next_state
        busy_ns    = busy_r;
        q1_wait_ns = q1_wait_r;
        q2_wait_ns = q2_wait_r;
        ent_ns     = ent_r;

        // Issued entry frees up for the next cycle
        if (do_issue_c) begin
            busy_ns[issue_idx_c] = 1'b0;
        end

        // CDB wake-up of waiting operands
        if (result_i.valid) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (busy_r[i] && q1_wait_r[i] && (ent_r[i].q1 == result_i.rob_tag)) begin
                    ent_ns[i].v1  = result_i.data;
                    q1_wait_ns[i] = 1'b0;
                end
                if (busy_r[i] && q2_wait_r[i] && (ent_r[i].q2 == result_i.rob_tag)) begin
                    ent_ns[i].v2  = result_i.data;
                    q2_wait_ns[i] = 1'b0;
                end
            end
        end

        // New entry, never overlaps a busy slot
        if (do_dispatch_c) begin
            busy_ns[alloc_idx_c]        = 1'b1;
            ent_ns[alloc_idx_c].op      = dispatch_i.op;
            ent_ns[alloc_idx_c].q1      = dispatch_i.q1;
            ent_ns[alloc_idx_c].q2      = dispatch_i.q2;
            ent_ns[alloc_idx_c].rob_tag = dispatch_i.rob_tag;
            // Same-cycle forward from the CDB
            ent_ns[alloc_idx_c].v1 = disp_hit1_c ? result_i.data : dispatch_i.v1;
            ent_ns[alloc_idx_c].v2 = disp_hit2_c ? result_i.data : dispatch_i.v2;
            q1_wait_ns[alloc_idx_c] = dispatch_i.q1_wait && !disp_hit1_c;
            q2_wait_ns[alloc_idx_c] = dispatch_i.q2_wait && !disp_hit2_c;
        end
    end

    // ------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl_regs
        if (!rst_ni) begin
            busy_r    <= '0;
            q1_wait_r <= '0;
            q2_wait_r <= '0;
        end else if (flush_i) begin
            // Drop everything, including a same-cycle dispatch
            busy_r    <= '0;
            q1_wait_r <= '0;
            q2_wait_r <= '0;
        end else begin
            busy_r    <= busy_ns;
            q1_wait_r <= q1_wait_ns;
            q2_wait_r <= q2_wait_ns;
        end
    end

    always_ff @(posedge clk_i) begin : proc_payload_regs
        ent_r <= ent_ns;
    end

endmodule

//--- ooo_pkg.sv
package ooo_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------

    // Operand and result width
    localparam int DATA_W = 32;
    // ROB tag width, 16 tags in flight
    localparam int ROB_TAG_W = 4;
    // Station depth and index width
    localparam int RS_SIZE = 4;
    localparam int RS_IDX_W = 2;
    // Shift amount comes from low bits of operand 2
    localparam int SHAMT_W = 5;

    // Multiplier retires 4 multiplier bits per step, 8 steps in total
    localparam int MUL_STEP_W = 4;
    localparam int MUL_STEPS = 8;
    localparam int MUL_CNT_W = 3;

    // ------------------------------------------------------------
    // Plain vector types
    // ------------------------------------------------------------

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [RS_IDX_W-1:0] rs_idx_t;

    // Integer ops handled by the execution unit
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_MUL
    } alu_op_e;

    // ------------------------------------------------------------
    // Bus structs
    // ------------------------------------------------------------

    // Renamed instruction into the station
    // A set wait bit means the value field is a don't-care
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        data_t    v1;
        logic     q1_wait;
        rob_tag_t q1;
        data_t    v2;
        logic     q2_wait;
        rob_tag_t q2;
        rob_tag_t rob_tag;
    } dispatch_t;

    // Ready instruction towards the execution unit
    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        data_t    v1;
        data_t    v2;
        rob_tag_t rob_tag;
    } issue_t;

    // Common data bus, single-cycle broadcast
    typedef struct packed {
        logic     valid;
        rob_tag_t rob_tag;
        data_t    data;
    } result_t;

endpackage
